/* Bender.yml */
package:
  name: dma_resp

export_include_dirs:
  - include

sources:
  # RTL in compile order
  - files:
      - hw/dma_resp_pkg.sv
      - hw/dma_resp_ingress.sv
      - hw/dma_resp_biu.sv
      - hw/dma_resp_done_merge.sv
      - hw/dma_resp_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/dma_resp_properties.sv
      - tests/dma_resp_tb.sv

/* dma_resp.f */
+incdir+include
hw/dma_resp_pkg.sv
hw/dma_resp_ingress.sv
hw/dma_resp_biu.sv
hw/dma_resp_done_merge.sv
hw/dma_resp_top.sv
tests/dma_resp_properties.sv
tests/dma_resp_tb.sv

/* hw/dma_resp_biu.sv */
//////////////////////////////////////////////////////////////////////
// Response lane bus interface unit
// Header decode, size skip, start address load and one memory write
// per data flit, with slot completion strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_biu (
  input  logic                   clk,
  input  logic                   rst,
  input  dma_resp_pkg::flit_t    in_flit,
  input  logic                   in_valid,
  output logic                   in_ready,
  output logic                   mem_sel,
  output dma_resp_pkg::mem_req_t mem_req,
  input  logic                   mem_ready,
  output logic                   done_en,
  output dma_resp_pkg::done_t    done_id
);
  import dma_resp_pkg::*;

  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    GET_SIZE = 2'b01,
    GET_ADDR = 2'b10,
    DATA     = 2'b11
  } state_e;

  state_e      state;
  state_e      nxt_state;
  logic [31:0] resp_addr;
  logic [31:0] nxt_resp_addr;
  done_t       resp_id;
  done_t       nxt_resp_id;
  logic        resp_last;
  logic        nxt_resp_last;

  // Packet end marker on the current flit
  logic in_end;

  assign in_end = (in_flit.ftype == FLIT_LAST) || (in_flit.ftype == FLIT_SINGLE);

  // Write port, address from the running counter, data from the raw view
  assign mem_req.addr  = resp_addr;
  assign mem_req.wdata = in_flit.content.word;

  //////////////////////////////////////////////////////////////////////
  // Parser FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state     = state;
    nxt_resp_addr = resp_addr;
    nxt_resp_id   = resp_id;
    nxt_resp_last = resp_last;
    in_ready      = 1'b0;
    mem_sel       = 1'b0;
    done_en       = 1'b0;
    done_id       = resp_id;

    case (state)
      IDLE: begin
        // Everything is popped here, non-headers are dropped
        in_ready = 1'b1;
        if (in_valid && (in_flit.ftype == FLIT_HEADER || in_flit.ftype == FLIT_SINGLE)) begin
          if (in_flit.content.hdr.pkt_type == PKT_L2R_RESP) begin
            // No data follows, slot done at once
            done_en = 1'b1;
            done_id = in_flit.content.hdr.req_id;
          end else if (in_flit.content.hdr.pkt_type == PKT_R2L_RESP &&
                       in_flit.ftype == FLIT_HEADER) begin
            nxt_resp_id   = in_flit.content.hdr.req_id;
            nxt_resp_last = in_flit.content.hdr.resp_last;
            nxt_state     = GET_SIZE;
          end
        end
      end

      GET_SIZE: begin
        // Size word is not checked
        in_ready = 1'b1;
        if (in_valid) begin
          nxt_state = GET_ADDR;
        end
      end

      GET_ADDR: begin
        in_ready = 1'b1;
        if (in_valid) begin
          nxt_resp_addr = in_flit.content.word;
          if (in_end) begin
            // Packet without data words
            nxt_state = IDLE;
            done_en   = resp_last;
          end else begin
            nxt_state = DATA;
          end
        end
      end

      DATA: begin
        // Hold the request until the port accepts it
        mem_sel  = in_valid;
        in_ready = mem_ready;
        if (in_valid && mem_ready) begin
          nxt_resp_addr = resp_addr + 32'(`DMA_RESP_ADDR_STEP);
          if (in_end) begin
            nxt_state = IDLE;
            // Slot finishes only on the last packet of the response
            done_en   = resp_last;
          end
        end
      end

      default: begin
        nxt_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      resp_last <= 1'b0;
    end else begin
      state     <= nxt_state;
      resp_last <= nxt_resp_last;
    end
  end

  // Running write address and stored request id of the current packet
  always_ff @(posedge clk) begin
    resp_addr <= nxt_resp_addr;
    resp_id   <= nxt_resp_id;
  end

endmodule

/* hw/dma_resp_done_merge.sv */
//////////////////////////////////////////////////////////////////////
// Completion merger
// One pending event per lane, rotating priority, one done per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_done_merge (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DMA_RESP_LANES-1:0] lane_done_en,
  input  dma_resp_pkg::done_t        lane_done_id [`DMA_RESP_LANES],
  output logic                       done_valid,
  output dma_resp_pkg::done_t        done_id
);
  import dma_resp_pkg::*;

  localparam int LANE_W = $clog2(`DMA_RESP_LANES);

  logic [`DMA_RESP_LANES-1:0] pend_q;
  done_t                      id_q [`DMA_RESP_LANES];
  logic [LANE_W-1:0]          ptr_q;
  logic [LANE_W-1:0]          grant_idx;
  logic                       grant_any;

  // First pending lane at or after the pointer
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_idx = ptr_q;
    for (int i = 0; i < `DMA_RESP_LANES; i++) begin
      idx = (int'(ptr_q) + i) % `DMA_RESP_LANES;
      if (!grant_any && pend_q[idx]) begin
        grant_any = 1'b1;
        grant_idx = LANE_W'(idx);
      end
    end
  end

  assign done_valid = grant_any;
  assign done_id    = id_q[grant_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= '0;
      ptr_q  <= '0;
    end else begin
      // New strobe wins over the clear of the served event
      for (int i = 0; i < `DMA_RESP_LANES; i++) begin
        pend_q[i] <= (pend_q[i] && !(grant_any && grant_idx == LANE_W'(i))) || lane_done_en[i];
      end
      if (grant_any) begin
        ptr_q <= (grant_idx == LANE_W'(`DMA_RESP_LANES - 1)) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `DMA_RESP_LANES; i++) begin
      if (lane_done_en[i]) begin
        id_q[i] <= lane_done_id[i];
      end
    end
  end

endmodule

/* hw/dma_resp_ingress.sv */
//////////////////////////////////////////////////////////////////////
// Ingress flit buffer with credit return
// Registered input stage, circular buffer, per-packet lane steering
// by request id
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_ingress (
  input  logic                        clk,
  input  logic                        rst,
  input  dma_resp_pkg::flit_t         noc_flit,
  input  logic                        noc_valid,
  output logic                        noc_credit,
  output dma_resp_pkg::flit_t         lane_flit,
  output logic [`DMA_RESP_LANES-1:0]  lane_valid,
  input  logic [`DMA_RESP_LANES-1:0]  lane_ready
);
  import dma_resp_pkg::*;

  localparam int PTR_W  = $clog2(`DMA_RESP_FIFO_DEPTH);
  localparam int LANE_W = $clog2(`DMA_RESP_LANES);

  // Buffer storage and pointers
  flit_t            buf_mem [`DMA_RESP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Input register, one cycle ahead of the buffer write
  flit_t in_q;
  logic  in_q_valid;

  // Head and steering
  logic              head_valid;
  logic              head_end;
  logic [LANE_W-1:0] head_lane;
  logic [LANE_W-1:0] cur_lane;
  logic [LANE_W-1:0] owner_q;
  logic              owned_q;
  logic              pop;

  //////////////////////////////////////////////////////////////////////
  // Head of buffer and lane select
  //////////////////////////////////////////////////////////////////////

  assign lane_flit  = buf_mem[rd_ptr];
  assign head_valid = (count != '0);
  assign head_end   = (lane_flit.ftype == FLIT_LAST) || (lane_flit.ftype == FLIT_SINGLE);

  // Lane from the header at the head, owner holds it for the rest
  assign head_lane = LANE_W'(lane_flit.content.hdr.req_id % `DMA_RESP_LANES);
  assign cur_lane  = owned_q ? owner_q : head_lane;

  always_comb begin
    for (int i = 0; i < `DMA_RESP_LANES; i++) begin
      lane_valid[i] = head_valid && (cur_lane == LANE_W'(i));
    end
  end

  assign pop = head_valid && lane_ready[cur_lane];

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    in_q <= noc_flit;
    if (in_q_valid) begin
      buf_mem[wr_ptr] <= in_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_q_valid <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      owned_q    <= 1'b0;
      owner_q    <= '0;
      noc_credit <= 1'b0;
    end else begin
      // No room check, the sender never overruns its credits
      in_q_valid <= noc_valid;
      if (in_q_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`DMA_RESP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`DMA_RESP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(in_q_valid) - (PTR_W + 1)'(pop);

      // Owner taken on the header pop, dropped on the packet end
      if (pop) begin
        if (head_end) begin
          owned_q <= 1'b0;
        end else if (!owned_q) begin
          owned_q <= 1'b1;
          owner_q <= cur_lane;
        end
      end

      // One credit back per pop
      noc_credit <= pop;
    end
  end

endmodule

/* hw/dma_resp_pkg.sv */
//////////////////////////////////////////////////////////////////////
// DMA response path types
// Flit and packet type codes, response header layout, flit content
// union, flit, done id and memory write request
//////////////////////////////////////////////////////////////////////

`include "dma_resp_consts.svh"

package dma_resp_pkg;

  // Flit type in the two top bits of every flit
  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10,
    FLIT_SINGLE  = 2'b11
  } flit_type_e;

  // Packet type in the header, only the two response codes are handled
  typedef enum logic [1:0] {
    PKT_RESERVED0 = 2'b00,
    PKT_RESERVED1 = 2'b01,
    PKT_L2R_RESP  = 2'b10,
    PKT_R2L_RESP  = 2'b11
  } pkt_type_e;

  // Request-table slot id
  typedef logic [$clog2(`DMA_RESP_TABLE_ENTRIES)-1:0] done_t;

  // Header word, packet type on top
  typedef struct packed {
    pkt_type_e pkt_type;
    done_t     req_id;
    logic      resp_last;
    logic [`DMA_RESP_FLIT_W-2-2-$bits(done_t)-1-1:0] rsvd;
  } resp_header_t;

  // Content word, header view or raw address/data view
  typedef union packed {
    resp_header_t                hdr;
    logic [`DMA_RESP_FLIT_W-3:0] word;
  } flit_content_u;

  typedef struct packed {
    flit_type_e    ftype;
    flit_content_u content;
  } flit_t;

  // Single-phase write, address and data together
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

endpackage

/* hw/dma_resp_top.sv */
//////////////////////////////////////////////////////////////////////
// DMA response path top level
// Ingress buffer, response lanes and completion merger
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_top (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_resp_pkg::flit_t        noc_flit,
  input  logic                       noc_valid,
  output logic                       noc_credit,
  output logic [`DMA_RESP_LANES-1:0] mem_sel,
  output dma_resp_pkg::mem_req_t     mem_req [`DMA_RESP_LANES],
  input  logic [`DMA_RESP_LANES-1:0] mem_ready,
  output logic                       done_valid,
  output dma_resp_pkg::done_t        done_id
);
  import dma_resp_pkg::*;

  // Ingress to lanes
  flit_t                      lane_flit;
  logic [`DMA_RESP_LANES-1:0] lane_valid;
  logic [`DMA_RESP_LANES-1:0] lane_ready;

  // Lanes to merger
  logic [`DMA_RESP_LANES-1:0] lane_done_en;
  done_t                      lane_done_id [`DMA_RESP_LANES];

  dma_resp_ingress dma_resp_ingress_inst (
    .clk        (clk),
    .rst        (rst),
    .noc_flit   (noc_flit),
    .noc_valid  (noc_valid),
    .noc_credit (noc_credit),
    .lane_flit  (lane_flit),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready)
  );

  for (genvar g = 0; g < `DMA_RESP_LANES; g++) begin : gen_lane
    dma_resp_biu dma_resp_biu_inst (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (lane_flit),
      .in_valid  (lane_valid[g]),
      .in_ready  (lane_ready[g]),
      .mem_sel   (mem_sel[g]),
      .mem_req   (mem_req[g]),
      .mem_ready (mem_ready[g]),
      .done_en   (lane_done_en[g]),
      .done_id   (lane_done_id[g])
    );
  end

  dma_resp_done_merge dma_resp_done_merge_inst (
    .clk          (clk),
    .rst          (rst),
    .lane_done_en (lane_done_en),
    .lane_done_id (lane_done_id),
    .done_valid   (done_valid),
    .done_id      (done_id)
  );

endmodule

/* include/dma_resp_consts.svh */
//////////////////////////////////////////////////////////////////////
// DMA response path constants
// Flit width, ingress buffer depth, lane count, request-table size
// and the byte step between data words
//////////////////////////////////////////////////////////////////////

`ifndef DMA_RESP_CONSTS_SVH
`define DMA_RESP_CONSTS_SVH

// Two type bits above a 32-bit content word
`define DMA_RESP_FLIT_W 34

// Ingress buffer entries, equal to the sender's starting credits
`define DMA_RESP_FIFO_DEPTH 16

// Response lanes, each with its own memory port
`define DMA_RESP_LANES 2

// Request-table slots, sets the request id width
`define DMA_RESP_TABLE_ENTRIES 4

// Byte increment per written data word
`define DMA_RESP_ADDR_STEP 4

`endif

/* tests/dma_resp_properties.sv */
//////////////////////////////////////////////////////////////////////
// Ingress assertions, bound into the ingress buffer
// Buffer fill bound, one lane owner at a time, steady stalled flit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_properties (
  input logic                                   clk,
  input logic                                   rst,
  input logic [$clog2(`DMA_RESP_FIFO_DEPTH):0]  count,
  input dma_resp_pkg::flit_t                    lane_flit,
  input logic [`DMA_RESP_LANES-1:0]             lane_valid,
  input logic [`DMA_RESP_LANES-1:0]             lane_ready
);

  // Failed assertion count, read by the testbench at the end
  int assert_fails = 0;

  // Credits keep the buffer within its depth
  count_within_depth: assert property (@(posedge clk) disable iff (rst)
    count <= `DMA_RESP_FIFO_DEPTH)
  else begin
    $error("ingress holds %0d flits, above the buffer depth", count);
    assert_fails++;
  end

  // Head flit offered to one lane only
  single_lane_valid: assert property (@(posedge clk) disable iff (rst)
    $onehot0(lane_valid))
  else begin
    $error("lane_valid %b offers the head flit to several lanes", lane_valid);
    assert_fails++;
  end

  // Stalled flit holds still, so the stalled lane's write data stays put
  stalled_flit_stable: assert property (@(posedge clk) disable iff (rst)
    (|(lane_valid & ~lane_ready)) |=> ($stable(lane_flit) && $stable(lane_valid)))
  else begin
    $error("head flit or lane_valid changed while its lane was stalled");
    assert_fails++;
  end

endmodule

/* tests/dma_resp_tb.sv */
//////////////////////////////////////////////////////////////////////
// DMA response path testbench
// Clock and reset, credit-counting packet driver, per-lane memory
// models, reference model of writes and dones, compare process
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "dma_resp_consts.svh"

module dma_resp_tb;
  import dma_resp_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int QUIET_CYCLES   = 20;

  logic                       clk = 1'b0;
  logic                       rst;
  flit_t                      noc_flit;
  logic                       noc_valid;
  logic                       noc_credit;
  logic [`DMA_RESP_LANES-1:0] mem_sel;
  mem_req_t                   mem_req [`DMA_RESP_LANES];
  logic [`DMA_RESP_LANES-1:0] mem_ready;
  logic                       done_valid;
  done_t                      done_id;

  // Stimulus stream and expected results per lane
  integer   seed;
  flit_t    stim [$];
  mem_req_t exp_wr [`DMA_RESP_LANES][$];
  done_t    exp_done [`DMA_RESP_LANES][$];
  mem_req_t got_wr [`DMA_RESP_LANES][$];
  done_t    got_done [$];

  // Sender state
  int credits;
  int sent;
  int credit_pulses;
  int cycles;

  dma_resp_top dma_resp_top_inst (
    .clk        (clk),
    .rst        (rst),
    .noc_flit   (noc_flit),
    .noc_valid  (noc_valid),
    .noc_credit (noc_credit),
    .mem_sel    (mem_sel),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .done_valid (done_valid),
    .done_id    (done_id)
  );

  bind dma_resp_ingress dma_resp_properties dma_resp_properties_inst (
    .clk        (clk),
    .rst        (rst),
    .count      (count),
    .lane_flit  (lane_flit),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready)
  );

  always #50 clk = ~clk;

  task automatic abort_test(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // Write request shown as addr:data
  task automatic check_mem_req(int lane, mem_req_t exp, mem_req_t act);
    if (act !== exp) begin
      abort_test($sformatf("error at %0t ns: mem_req[%0d] expected %h:%h, got %h:%h",
                           $time, lane, exp.addr, exp.wdata, act.addr, act.wdata));
    end
  endtask

  task automatic check_done(done_t exp, done_t act);
    if (act !== exp) begin
      abort_test($sformatf("error at %0t ns: done_id expected %0d, got %0d", $time, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Packet builders
  //////////////////////////////////////////////////////////////////////

  // Header-only packet, reserved header bits random
  task automatic add_single(pkt_type_e t, done_t id);
    flit_t f;
    f.ftype                  = FLIT_SINGLE;
    f.content.word           = $random(seed);
    f.content.hdr.pkt_type   = t;
    f.content.hdr.req_id     = id;
    f.content.hdr.resp_last  = 1'b1;
    stim.push_back(f);
  endtask

  // Header, size, start address, then n data words, last flit flagged
  task automatic add_multi(pkt_type_e t, done_t id, logic last, logic [31:0] addr, int n);
    flit_t f;
    f.ftype                  = FLIT_HEADER;
    f.content.word           = $random(seed);
    f.content.hdr.pkt_type   = t;
    f.content.hdr.req_id     = id;
    f.content.hdr.resp_last  = last;
    stim.push_back(f);
    f.ftype        = FLIT_PAYLOAD;
    f.content.word = 32'(n * `DMA_RESP_ADDR_STEP);
    stim.push_back(f);
    f.content.word = addr;
    stim.push_back(f);
    for (int k = 0; k < n; k++) begin
      f.ftype        = (k == n - 1) ? FLIT_LAST : FLIT_PAYLOAD;
      f.content.word = $random(seed);
      stim.push_back(f);
    end
  endtask

  task automatic build_stimulus();
    int    n;
    done_t id;
    // Directed cases first
    add_single(PKT_L2R_RESP, 2'd1);
    add_single(PKT_L2R_RESP, 2'd2);
    add_multi(PKT_R2L_RESP, 2'd0, 1'b1, 32'h0000_1000, 4);
    add_multi(PKT_R2L_RESP, 2'd3, 1'b0, 32'h0000_2000, 3);
    add_multi(PKT_R2L_RESP, 2'd3, 1'b1, 32'h0000_200c, 2);
    add_multi(PKT_RESERVED0, 2'd1, 1'b1, 32'h0000_3000, 2);
    add_single(PKT_RESERVED1, 2'd0);
    // Random mix over both lanes
    for (int k = 0; k < 40; k++) begin
      id = done_t'($random(seed));
      n  = 1 + int'($unsigned($random(seed)) % 6);
      case (2'($random(seed)))
        2'd0:    add_single(PKT_L2R_RESP, id);
        2'd1:    add_multi(PKT_RESERVED1, id, 1'b1, 32'h0, n);
        default: add_multi(PKT_R2L_RESP, id, 1'($random(seed)),
                           32'($random(seed)) & 32'hffff_fffc, n);
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Lane is id mod lanes; r2l writes from the start address upward
  function automatic void expected_writes();
    int           i;
    int           l;
    flit_t        f;
    resp_header_t h;
    mem_req_t     w;
    logic [31:0]  a;
    logic         at_end;
    i = 0;
    while (i < stim.size()) begin
      f = stim[i];
      h = f.content.hdr;
      l = int'(h.req_id) % `DMA_RESP_LANES;
      i++;
      if (f.ftype == FLIT_SINGLE) begin
        // l2r finishes at once, other single packets vanish
        if (h.pkt_type == PKT_L2R_RESP) begin
          exp_done[l].push_back(h.req_id);
        end
      end else if (h.pkt_type == PKT_R2L_RESP) begin
        // Size word ignored, address word follows it
        a      = stim[i + 1].content.word;
        i      = i + 2;
        at_end = 1'b0;
        while (!at_end) begin
          w.addr  = a;
          w.wdata = stim[i].content.word;
          exp_wr[l].push_back(w);
          at_end = (stim[i].ftype == FLIT_LAST);
          a      = a + 32'(`DMA_RESP_ADDR_STEP);
          i++;
        end
        if (h.resp_last) begin
          exp_done[l].push_back(h.req_id);
        end
      end else begin
        // Dropped packet, skip through its last flit
        while (stim[i].ftype != FLIT_LAST) begin
          i++;
        end
        i++;
      end
    end
  endfunction

  function automatic bit all_expected_seen();
    bit seen;
    seen = (got_done.size() == 0);
    for (int l = 0; l < `DMA_RESP_LANES; l++) begin
      seen = seen && (exp_wr[l].size() == 0) && (exp_done[l].size() == 0) &&
             (got_wr[l].size() == 0);
    end
    return seen;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driver, memory models and compare
  //////////////////////////////////////////////////////////////////////

  // Reset sampled on the edge, inputs change 10 ns later
  always @(posedge clk) begin : drive
    logic live;
    live = !rst;
    #10;
    if (live) begin
      for (int l = 0; l < `DMA_RESP_LANES; l++) begin
        mem_ready[l] = (($random(seed) & 3) != 0);
      end
      // Send only while holding a credit, with random gaps
      if (sent < stim.size() && credits > 0 && ($random(seed) & 7) != 0) begin
        noc_flit  = stim[sent];
        noc_valid = 1'b1;
        credits--;
        sent++;
      end else begin
        noc_valid = 1'b0;
      end
    end
  end

  // Writes land on sel and ready, credits come back one per pulse
  always @(negedge clk) begin
    if (!rst) begin
      for (int l = 0; l < `DMA_RESP_LANES; l++) begin
        if (mem_sel[l] && mem_ready[l]) begin
          got_wr[l].push_back(mem_req[l]);
        end
      end
      if (done_valid) begin
        got_done.push_back(done_id);
      end
      if (noc_credit) begin
        credits++;
        credit_pulses++;
        if (credits > `DMA_RESP_FIFO_DEPTH) begin
          abort_test("noc_credit returned more credits than flits were sent");
        end
      end
    end
  end

  always @(posedge clk) begin : compare
    mem_req_t act_req;
    done_t    act_id;
    int       lane;
    for (int l = 0; l < `DMA_RESP_LANES; l++) begin
      while (got_wr[l].size() != 0) begin
        act_req = got_wr[l].pop_front();
        if (exp_wr[l].size() == 0) begin
          abort_test($sformatf("lane %0d wrote address %h when no write was expected",
                               l, act_req.addr));
        end else begin
          check_mem_req(l, exp_wr[l].pop_front(), act_req);
        end
      end
    end
    // Done order is kept within a lane only
    while (got_done.size() != 0) begin
      act_id = got_done.pop_front();
      lane   = int'(act_id) % `DMA_RESP_LANES;
      if (exp_done[lane].size() == 0) begin
        abort_test($sformatf("done_valid reported id %0d with no completion expected", act_id));
      end else begin
        check_done(exp_done[lane].pop_front(), act_id);
      end
    end
  end

  initial begin
    seed          = 32'h55c7_f8f5;
    rst           = 1'b1;
    noc_valid     = 1'b0;
    noc_flit      = '0;
    mem_ready     = '0;
    credits       = `DMA_RESP_FIFO_DEPTH;
    sent          = 0;
    credit_pulses = 0;
    build_stimulus();
    expected_writes();
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;

    // Stream drained, all credits home, all expected events seen
    cycles = 0;
    while (!(sent == stim.size() && credits == `DMA_RESP_FIFO_DEPTH && all_expected_seen()) &&
           cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      if (sent == stim.size() && all_expected_seen()) begin
        // Every write and done arrived, only credits are missing
        abort_test($sformatf("error at %0t ns: noc_credit pulses expected %0d, got %0d",
                             $time, sent, credit_pulses));
      end else begin
        abort_test("timeout waiting for the packet stream to drain and complete");
      end
    end

    // Quiet window catches late writes, dones or credits
    cycles = 0;
    while (cycles < QUIET_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (dma_resp_top_inst.dma_resp_ingress_inst.dma_resp_properties_inst.assert_fails != 0) begin
      abort_test("bound ingress assertions reported failures");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
